// File: files.f
+incdir+.
cpuPkg.sv
aluUnit.sv
interruptControl.sv
cpuSequencer.sv
cpuTop.sv
tb_cpuTop.sv

// File: tb_cpuTop.sv
/* testbench for cpuTop with memory model, reference model of instruction results,
   sync checker, interrupt driver and watchdog */
`default_nettype none
`include "cpu_consts.svh"

module tb_cpuTop;

  localparam int tReset   = 0;
  localparam int tFlags   = 1;
  localparam int tAlu     = 2;
  localparam int tJmp     = 3;
  localparam int tIrq     = 4;
  localparam int tMasked  = 5;
  localparam int tNmi     = 6;
  localparam int tUnknown = 7;

  logic                   fastClk;
  logic                   rst;
  logic                   irqN;
  logic                   nmiN;
  logic [`CPU_DATA_W-1:0] dataIn;
  logic [`CPU_ADDR_W-1:0] addr;
  logic                   sync;
  logic [`CPU_DATA_W-1:0] accum;
  logic [`CPU_DATA_W-1:0] status;

  logic [`CPU_DATA_W-1:0] mem [0:65535];

  // expected state at each sync, in order
  logic [`CPU_ADDR_W-1:0] expPcQ[$];
  logic [`CPU_DATA_W-1:0] expAQ[$];
  logic [`CPU_DATA_W-1:0] expPQ[$];
  bit                     expAKnownQ[$];
  int                     testIdQ[$];

  // model while the program is laid out
  logic [`CPU_ADDR_W-1:0] modelPc;
  logic [`CPU_DATA_W-1:0] modelA;
  logic [`CPU_DATA_W-1:0] modelP;
  bit                     modelAKnown;
  int                     lastTest;

  int          irqIdx;
  int          maskedIdx;
  int          nmiIdx;
  int          addrErrors;
  int          accErrors;
  int          statusErrors;
  bit          buildDone;
  bit          checksDone;
  int unsigned seedDummy;

  // combinational memory
  assign dataIn = mem[addr];

  cpuTop uut (
    .fastClk (fastClk),
    .rst     (rst),
    .irqN    (irqN),
    .nmiN    (nmiN),
    .dataIn  (dataIn),
    .addr    (addr),
    .sync    (sync),
    .accum   (accum),
    .status  (status)
  );

  initial begin
    fastClk = 1'b0;
    forever #5 fastClk = ~fastClk;
  end

  // expected {A, P} after one instruction
  function automatic logic [15:0] refModel(input logic [7:0] op, input logic [7:0] operand,
                                           input logic [7:0] a, input logic [7:0] p);
    logic [8:0] sum;
    logic [7:0] na;
    logic [7:0] np;
    bit         setsNz;
    na     = a;
    np     = p;
    setsNz = (op == cpuPkg::opLdaImm) || (op == cpuPkg::opAdcImm) ||
             (op == cpuPkg::opAndImm) || (op == cpuPkg::opOraImm) ||
             (op == cpuPkg::opEorImm);
    case (op)
      cpuPkg::opLdaImm: na = operand;
      cpuPkg::opAdcImm: begin
        sum         = a + operand + p[`FLAG_C];
        na          = sum[7:0];
        np[`FLAG_C] = sum[8];
        // signed overflow, like-signed inputs with a sign flip
        np[`FLAG_V] = (a[7] == operand[7]) && (na[7] != a[7]);
      end
      cpuPkg::opAndImm: na = a & operand;
      cpuPkg::opOraImm: na = a | operand;
      cpuPkg::opEorImm: na = a ^ operand;
      cpuPkg::opSec:    np[`FLAG_C] = 1'b1;
      cpuPkg::opClc:    np[`FLAG_C] = 1'b0;
      cpuPkg::opSei:    np[`FLAG_I] = 1'b1;
      cpuPkg::opCli:    np[`FLAG_I] = 1'b0;
      default:          na = a;
    endcase
    if (setsNz) begin
      np[`FLAG_N] = na[7];
      np[`FLAG_Z] = (na == 8'h00);
    end
    return {na, np};
  endfunction

  function automatic string testName(input int id);
    case (id)
      tReset:   return "reset";
      tFlags:   return "flag ops";
      tAlu:     return "alu immediates";
      tJmp:     return "jmp absolute";
      tIrq:     return "irq unmasked";
      tMasked:  return "irq masked";
      tNmi:     return "nmi";
      default:  return "unknown opcode";
    endcase
  endfunction

  task automatic pushRecord();
    expPcQ.push_back(modelPc);
    expAQ.push_back(modelA);
    expPQ.push_back(modelP);
    expAKnownQ.push_back(modelAKnown);
    testIdQ.push_back(lastTest);
  endtask

  // implied opcodes keep the fill byte as their dummy operand
  task automatic placeOp(input logic [7:0] op, input logic [7:0] operand, input bit imm,
                         input int test);
    logic [15:0] result;
    mem[modelPc] = op;
    if (imm)
      mem[modelPc + 16'd1] = operand;
    pushRecord();
    result   = refModel(op, mem[modelPc + 16'd1], modelA, modelP);
    modelA   = result[15:8];
    modelP   = result[7:0];
    if (op == cpuPkg::opLdaImm)
      modelAKnown = 1'b1;
    modelPc  = modelPc + 16'd2;
    lastTest = test;
  endtask

  task automatic placeJmp(input logic [15:0] target, input int test);
    mem[modelPc]         = cpuPkg::opJmpAbs;
    mem[modelPc + 16'd1] = target[7:0];
    mem[modelPc + 16'd2] = target[15:8];
    pushRecord();
    modelPc  = target;
    lastTest = test;
  endtask

  task automatic setVector(input logic [15:0] vec, input logic [15:0] target);
    mem[vec]         = target[7:0];
    mem[vec + 16'd1] = target[15:8];
  endtask

  task automatic enterVector(input logic [15:0] vec, input logic [15:0] target,
                             input int test);
    setVector(vec, target);
    modelPc          = target;
    modelP[`FLAG_I]  = 1'b1;
    lastTest         = test;
  endtask

  task automatic buildProgram();
    logic [7:0] aluOps [0:4];
    int         i;
    aluOps[0] = cpuPkg::opLdaImm;
    aluOps[1] = cpuPkg::opAdcImm;
    aluOps[2] = cpuPkg::opAndImm;
    aluOps[3] = cpuPkg::opOraImm;
    aluOps[4] = cpuPkg::opEorImm;
    // fill depends on both address bytes
    for (i = 0; i < 65536; i++)
      mem[i] = i[7:0] ^ i[15:8] ^ 8'h5A;
    setVector(`CPU_RES_VEC, 16'h0200);
    modelPc     = 16'h0200;
    modelA      = 8'h00;
    modelP      = 8'h24;
    modelAKnown = 1'b0;
    lastTest    = tReset;
    placeOp(cpuPkg::opSec, 8'h00, 1'b0, tFlags);
    placeOp(cpuPkg::opClc, 8'h00, 1'b0, tFlags);
    placeOp(cpuPkg::opSei, 8'h00, 1'b0, tFlags);
    placeOp(cpuPkg::opCli, 8'h00, 1'b0, tFlags);
    placeOp(cpuPkg::opSec, 8'h00, 1'b0, tFlags);
    placeOp(cpuPkg::opClc, 8'h00, 1'b0, tFlags);
    placeOp(8'hFF, 8'h00, 1'b0, tUnknown);
    placeJmp(16'h0480, tJmp);
    // random immediates, the first one loads A
    placeOp(cpuPkg::opLdaImm, 8'($urandom), 1'b1, tAlu);
    for (i = 1; i < 40; i++)
      placeOp(aluOps[$urandom % 5], 8'($urandom), 1'b1, tAlu);
    // I is clear here, irq taken after this NOP
    irqIdx = expPcQ.size();
    placeOp(cpuPkg::opNop, 8'h00, 1'b0, tIrq);
    enterVector(`CPU_IRQ_VEC, 16'h3000, tIrq);
    placeOp(cpuPkg::opNop, 8'h00, 1'b0, tIrq);
    maskedIdx = expPcQ.size();
    placeOp(cpuPkg::opNop, 8'h00, 1'b0, tMasked);
    placeOp(cpuPkg::opNop, 8'h00, 1'b0, tMasked);
    nmiIdx = expPcQ.size();
    placeOp(cpuPkg::opNop, 8'h00, 1'b0, tNmi);
    placeOp(cpuPkg::opNop, 8'h00, 1'b0, tNmi);
    enterVector(`CPU_NMI_VEC, 16'h4000, tNmi);
    placeOp(cpuPkg::opLdaImm, 8'($urandom), 1'b1, tNmi);
    placeOp(cpuPkg::opNop, 8'h00, 1'b0, tNmi);
    placeOp(cpuPkg::opNop, 8'h00, 1'b0, tNmi);
    placeJmp(16'h5000, tJmp);
    placeOp(cpuPkg::opAdcImm, 8'($urandom), 1'b1, tAlu);
    // jump to itself, seen on two passes
    placeJmp(16'h5002, tJmp);
    pushRecord();
  endtask

  initial begin
    seedDummy    = $urandom(32'h7488);
    rst          = 1'b1;
    irqN         = 1'b1;
    nmiN         = 1'b1;
    addrErrors   = 0;
    accErrors    = 0;
    statusErrors = 0;
    buildProgram();
    buildDone = 1'b1;
    repeat (3) @(posedge fastClk);
    #1;
    rst = 1'b0;
    wait (checksDone);
    $display("Checked %0d syncs: %0d addr errors, %0d accum errors, %0d status errors",
             expPcQ.size(), addrErrors, accErrors, statusErrors);
    if (addrErrors + accErrors + statusErrors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // irq and nmi pins move 1 unit after the edge that opens a fetch
  initial begin : driveInterrupts
    int syncCount;
    syncCount = 0;
    wait (buildDone && !rst);
    while (!checksDone) begin
      @(posedge fastClk);
      #1;
      if (sync) begin
        if (syncCount == irqIdx || syncCount == maskedIdx)
          irqN = 1'b0;
        else if (syncCount == irqIdx + 1 || syncCount == maskedIdx + 1)
          irqN = 1'b1;
        else if (syncCount == nmiIdx)
          nmiN = 1'b0;
        else if (syncCount == nmiIdx + 4)
          nmiN = 1'b1;
        syncCount++;
      end
    end
  end

  initial begin : checkSyncs
    int idx;
    idx = 0;
    wait (buildDone && !rst);
    while (idx < expPcQ.size()) begin
      @(negedge fastClk);
      if (sync) begin
        if (addr !== expPcQ[idx]) begin
          $display("** Error %s, sync %0d, addr: expected %h, actual %h",
                   testName(testIdQ[idx]), idx, expPcQ[idx], addr);
          addrErrors++;
        end
        if (expAKnownQ[idx] && accum !== expAQ[idx]) begin
          $display("** Error %s, sync %0d, accum: expected %h, actual %h",
                   testName(testIdQ[idx]), idx, expAQ[idx], accum);
          accErrors++;
        end
        if (status !== expPQ[idx]) begin
          $display("** Error %s, sync %0d, status: expected %h, actual %h",
                   testName(testIdQ[idx]), idx, expPQ[idx], status);
          statusErrors++;
        end
        idx++;
      end
    end
    checksDone = 1'b1;
  end

  initial begin : watchdog
    int limit;
    wait (buildDone);
    limit = expPcQ.size() * 3 + 200;
    repeat (limit) @(posedge fastClk);
    if (!checksDone) begin
      $display("Timeout: the core did not reach its last expected sync in %0d cycles", limit);
      $display("Test FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: cpuTop.sv
/* top level of the core, joins the ALU,
   the interrupt controller and the sequencer */
`default_nettype none
`include "cpu_consts.svh"

module cpuTop (
  input  wire                   fastClk,
  input  wire                   rst,
  input  wire                   irqN,
  input  wire                   nmiN,
  input  wire [`CPU_DATA_W-1:0] dataIn,
  output wire [`CPU_ADDR_W-1:0] addr,
  output wire                   sync,
  output wire [`CPU_DATA_W-1:0] accum,
  output wire [`CPU_DATA_W-1:0] status
);

  // sequencer to ALU and back
  wire [`CPU_DATA_W-1:0] aluA;
  wire [`CPU_DATA_W-1:0] aluB;
  wire                   carryIn;
  wire cpuPkg::aluOp_t   aluOp;
  wire [`CPU_DATA_W-1:0] aluResult;
  wire                   resN;
  wire                   resZ;
  wire                   resC;
  wire                   resV;

  // interrupt handshake
  wire                   intReq;
  wire cpuPkg::vecSel_t  vecSel;
  wire                   intAck;
  wire                   iFlag;

  aluUnit alu (
    .aluA      (aluA),
    .aluB      (aluB),
    .carryIn   (carryIn),
    .aluOp     (aluOp),
    .aluResult (aluResult),
    .resN      (resN),
    .resZ      (resZ),
    .resC      (resC),
    .resV      (resV)
  );

  interruptControl intCtrl (
    .fastClk (fastClk),
    .rst     (rst),
    .irqN    (irqN),
    .nmiN    (nmiN),
    .iFlag   (iFlag),
    .intAck  (intAck),
    .intReq  (intReq),
    .vecSel  (vecSel)
  );

  cpuSequencer seq (
    .fastClk   (fastClk),
    .rst       (rst),
    .dataIn    (dataIn),
    .intReq    (intReq),
    .vecSel    (vecSel),
    .aluResult (aluResult),
    .resN      (resN),
    .resZ      (resZ),
    .resC      (resC),
    .resV      (resV),
    .addr      (addr),
    .sync      (sync),
    .accum     (accum),
    .status    (status),
    .aluA      (aluA),
    .aluB      (aluB),
    .carryIn   (carryIn),
    .aluOp     (aluOp),
    .intAck    (intAck),
    .iFlag     (iFlag)
  );

endmodule

`default_nettype wire

// File: cpuSequencer.sv
/* program counter, instruction register, accumulator, status flags,
   opcode decode and the cycle state machine */
`default_nettype none
`include "cpu_consts.svh"

module cpuSequencer (
  input  wire                    fastClk,
  input  wire                    rst,
  input  wire [`CPU_DATA_W-1:0]  dataIn,
  input  wire                    intReq,
  input  wire cpuPkg::vecSel_t   vecSel,
  input  wire [`CPU_DATA_W-1:0]  aluResult,
  input  wire                    resN,
  input  wire                    resZ,
  input  wire                    resC,
  input  wire                    resV,
  output logic [`CPU_ADDR_W-1:0] addr,
  output logic                   sync,
  output logic [`CPU_DATA_W-1:0] accum,
  output logic [`CPU_DATA_W-1:0] status,
  output logic [`CPU_DATA_W-1:0] aluA,
  output logic [`CPU_DATA_W-1:0] aluB,
  output logic                   carryIn,
  output cpuPkg::aluOp_t         aluOp,
  output logic                   intAck,
  output logic                   iFlag
);

  cpuPkg::seqState_t     state;
  cpuPkg::seqState_t     nextState;
  cpuPkg::opcode_t       ir;
  logic [`CPU_ADDR_W-1:0] pc;
  // low address byte of JMP, held for its third cycle
  logic [`CPU_DATA_W-1:0] operandLo;
  // vector being fetched, reset vector after rst
  logic [`CPU_ADDR_W-1:0] vecAddr;
  logic                   intTaken;

  logic flagC;
  logic flagZ;
  logic flagI;
  logic flagV;
  logic flagN;

  // decode of the current instruction
  logic loadAcc;
  logic setC;
  logic clrC;
  logic setI;
  logic clrI;
  logic isJmp;
  logic lastCycle;

  always_comb begin
    aluOp   = cpuPkg::aluPass;
    loadAcc = 1'b0;
    setC    = 1'b0;
    clrC    = 1'b0;
    setI    = 1'b0;
    clrI    = 1'b0;
    isJmp   = 1'b0;
    // NOP and unknown opcodes fall through with no effect
    case (ir)
      cpuPkg::opLdaImm: loadAcc = 1'b1;
      cpuPkg::opAdcImm: begin
        aluOp   = cpuPkg::aluAdd;
        loadAcc = 1'b1;
      end
      cpuPkg::opAndImm: begin
        aluOp   = cpuPkg::aluAnd;
        loadAcc = 1'b1;
      end
      cpuPkg::opOraImm: begin
        aluOp   = cpuPkg::aluOr;
        loadAcc = 1'b1;
      end
      cpuPkg::opEorImm: begin
        aluOp   = cpuPkg::aluEor;
        loadAcc = 1'b1;
      end
      cpuPkg::opSec:    setC = 1'b1;
      cpuPkg::opClc:    clrC = 1'b1;
      cpuPkg::opSei:    setI = 1'b1;
      cpuPkg::opCli:    clrI = 1'b1;
      cpuPkg::opJmpAbs: isJmp = 1'b1;
      default:          loadAcc = 1'b0;
    endcase
  end

  // instruction boundary, where interrupts get their chance
  assign lastCycle = ((state == cpuPkg::stOperand) && !isJmp) || (state == cpuPkg::stAbsHi);

  always_comb begin
    case (state)
      cpuPkg::stVecLo:   nextState = cpuPkg::stVecHi;
      cpuPkg::stVecHi:   nextState = cpuPkg::stFetch;
      cpuPkg::stFetch:   nextState = cpuPkg::stOperand;
      cpuPkg::stOperand: nextState = isJmp ? cpuPkg::stAbsHi : cpuPkg::stFetch;
      cpuPkg::stAbsHi:   nextState = cpuPkg::stFetch;
      default:           nextState = cpuPkg::stVecLo;
    endcase
    if (lastCycle && intReq) begin
      nextState = cpuPkg::stVecLo;
    end
  end

  always_comb begin
    case (state)
      cpuPkg::stVecLo: addr = vecAddr;
      cpuPkg::stVecHi: addr = vecAddr + 1'b1;
      default:         addr = pc;
    endcase
  end

  assign sync    = (state == cpuPkg::stFetch);
  assign intAck  = (state == cpuPkg::stVecLo) && intTaken;
  assign aluA    = accum;
  // operand comes straight off the bus in stOperand
  assign aluB    = dataIn;
  assign carryIn = flagC;
  assign iFlag   = flagI;

  always_comb begin
    status          = '0;
    // unused bit 5 always reads as one
    status[5]       = 1'b1;
    status[`FLAG_C] = flagC;
    status[`FLAG_Z] = flagZ;
    status[`FLAG_I] = flagI;
    status[`FLAG_V] = flagV;
    status[`FLAG_N] = flagN;
  end

  always_ff @(posedge fastClk) begin
    if (rst) begin
      state    <= cpuPkg::stVecLo;
      ir       <= cpuPkg::opNop;
      vecAddr  <= `CPU_RES_VEC;
      intTaken <= 1'b0;
      accum    <= '0;
      flagC    <= 1'b0;
      flagZ    <= 1'b0;
      flagI    <= 1'b1;
      flagV    <= 1'b0;
      flagN    <= 1'b0;
    end else begin
      state <= nextState;
      if (state == cpuPkg::stVecLo) begin
        flagI    <= 1'b1;
        intTaken <= 1'b0;
      end
      if (state == cpuPkg::stFetch) begin
        ir <= cpuPkg::opcode_t'(dataIn);
      end
      if (state == cpuPkg::stOperand) begin
        if (loadAcc) begin
          accum <= aluResult;
          flagN <= resN;
          flagZ <= resZ;
        end
        // C and V only move on add
        if (aluOp == cpuPkg::aluAdd) begin
          flagC <= resC;
          flagV <= resV;
        end
        if (setC) flagC <= 1'b1;
        if (clrC) flagC <= 1'b0;
        if (setI) flagI <= 1'b1;
        if (clrI) flagI <= 1'b0;
      end
      if (lastCycle && intReq) begin
        vecAddr  <= (vecSel == cpuPkg::vecNmi) ? `CPU_NMI_VEC : `CPU_IRQ_VEC;
        intTaken <= 1'b1;
      end
    end
  end

  always_ff @(posedge fastClk) begin
    case (state)
      cpuPkg::stVecLo: pc[`CPU_DATA_W-1:0] <= dataIn;
      cpuPkg::stVecHi: pc[`CPU_ADDR_W-1:`CPU_DATA_W] <= dataIn;
      cpuPkg::stFetch: pc <= pc + 1'b1;
      cpuPkg::stOperand: begin
        operandLo <= dataIn;
        pc        <= pc + 1'b1;
      end
      cpuPkg::stAbsHi: pc <= {dataIn, operandLo};
      default:         pc <= pc;
    endcase
  end

  // fetch only follows a vector high byte or the end of an instruction
  syncInFetch: assert property (@(posedge fastClk) disable iff (rst)
    sync |-> $past((state == cpuPkg::stVecHi) || lastCycle))
    else $error("cpuSequencer: sync outside of the fetch cycle");

  vecLoToHi: assert property (@(posedge fastClk) disable iff (rst)
    (state == cpuPkg::stVecLo) |=> (state == cpuPkg::stVecHi))
    else $error("cpuSequencer: vector low fetch not followed by high fetch");

endmodule

`default_nettype wire

// File: interruptControl.sv
/* IRQ and NMI input registers, NMI falling edge latch,
   IRQ masking and request and vector select outputs */
`default_nettype none
`include "cpu_consts.svh"

module interruptControl (
  input  wire              fastClk,
  input  wire              rst,
  input  wire              irqN,
  input  wire              nmiN,
  input  wire              iFlag,
  input  wire              intAck,
  output logic             intReq,
  output cpuPkg::vecSel_t  vecSel
);

  // pins sampled once on fastClk
  logic irqSync;
  logic nmiSync;
  // last cycle's nmi level for the edge detect
  logic nmiPrev;
  logic nmiFall;
  logic nmiLatch;
  // latch value in the cycle the sequencer took its decision
  logic nmiArmed;

  always_ff @(posedge fastClk) begin
    if (rst) begin
      irqSync <= 1'b1;
      nmiSync <= 1'b1;
      nmiPrev <= 1'b1;
    end else begin
      irqSync <= irqN;
      nmiSync <= nmiN;
      nmiPrev <= nmiSync;
    end
  end

  assign nmiFall = nmiPrev & ~nmiSync;

  always_ff @(posedge fastClk) begin
    if (rst) begin
      nmiLatch <= 1'b0;
      nmiArmed <= 1'b0;
    end else begin
      nmiArmed <= nmiLatch;
      // a fresh edge beats the acknowledge of an older one
      if (nmiFall) begin
        nmiLatch <= 1'b1;
      end else if (intAck && nmiArmed) begin
        nmiLatch <= 1'b0;
      end
    end
  end

  // NMI first, IRQ only while unmasked
  assign intReq = nmiLatch | (~irqSync & ~iFlag);
  assign vecSel = nmiLatch ? cpuPkg::vecNmi : cpuPkg::vecIrq;

  ackNeedsReq: assert property (@(posedge fastClk) disable iff (rst)
    intAck |-> intReq)
    else $error("interruptControl: intAck without a pending request");

  nmiEdgeLatched: assert property (@(posedge fastClk) disable iff (rst)
    $fell(nmiSync) |=> nmiLatch)
    else $error("interruptControl: NMI edge was not latched");

endmodule

`default_nettype wire

// File: aluUnit.sv
/* combinational ALU with pass, add with carry, AND, OR and EOR
   and N, Z, C, V results */
`default_nettype none
`include "cpu_consts.svh"

module aluUnit (
  input  wire [`CPU_DATA_W-1:0]  aluA,
  input  wire [`CPU_DATA_W-1:0]  aluB,
  input  wire                    carryIn,
  input  wire cpuPkg::aluOp_t    aluOp,
  output logic [`CPU_DATA_W-1:0] aluResult,
  output logic                   resN,
  output logic                   resZ,
  output logic                   resC,
  output logic                   resV
);

  // one extra bit so the carry out lands on top
  logic [`CPU_DATA_W:0] sum;
  logic                 signA;
  logic                 signB;
  logic                 signSum;

  assign sum = {1'b0, aluA} + {1'b0, aluB} + {{`CPU_DATA_W{1'b0}}, carryIn};

  assign signA   = aluA[`CPU_DATA_W-1];
  assign signB   = aluB[`CPU_DATA_W-1];
  assign signSum = sum[`CPU_DATA_W-1];

  always_comb begin
    // carry passes through and V stays low unless adding
    aluResult = aluB;
    resC      = carryIn;
    resV      = 1'b0;
    case (aluOp)
      cpuPkg::aluPass: begin
        aluResult = aluB;
      end
      cpuPkg::aluAdd: begin
        aluResult = sum[`CPU_DATA_W-1:0];
        resC      = sum[`CPU_DATA_W];
        // overflow when like-signed inputs give a result of the other sign
        resV      = (signA ~^ signB) & (signA ^ signSum);
      end
      cpuPkg::aluAnd: begin
        aluResult = aluA & aluB;
      end
      cpuPkg::aluOr: begin
        aluResult = aluA | aluB;
      end
      cpuPkg::aluEor: begin
        aluResult = aluA ^ aluB;
      end
      default: begin
        aluResult = aluB;
      end
    endcase
  end

  // N and Z follow the result for every operation
  assign resN = aluResult[`CPU_DATA_W-1];
  assign resZ = (aluResult == '0);

  always_comb begin
    assert #0 (!$isunknown(aluOp))
      else $error("aluUnit: aluOp is not a known value");
  end

endmodule

`default_nettype wire

// File: cpuPkg.sv
/* opcode, ALU operation, sequencer state
   and vector select enums */
`default_nettype none
`include "cpu_consts.svh"

package cpuPkg;

  // real 6502 encodings of the opcodes the core knows
  typedef enum logic [`CPU_DATA_W-1:0] {
    opLdaImm = 8'hA9,
    opAdcImm = 8'h69,
    opAndImm = 8'h29,
    opOraImm = 8'h09,
    opEorImm = 8'h49,
    opSec    = 8'h38,
    opClc    = 8'h18,
    opSei    = 8'h78,
    opCli    = 8'h58,
    opNop    = 8'hEA,
    opJmpAbs = 8'h4C
  } opcode_t;

  typedef enum logic [2:0] {
    aluPass,
    aluAdd,
    aluAnd,
    aluOr,
    aluEor
  } aluOp_t;

  // one state per bus cycle
  typedef enum logic [2:0] {
    stVecLo,
    stVecHi,
    stFetch,
    stOperand,
    stAbsHi
  } seqState_t;

  // which interrupt source a request stands for
  typedef enum logic {
    vecNmi,
    vecIrq
  } vecSel_t;

endpackage

`default_nettype wire

// File: cpu_consts.svh
/* data and address widths, interrupt and reset vector addresses,
   status register bit positions */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// low byte of each vector, high byte sits at the next address
`define CPU_NMI_VEC 16'hFFFA
`define CPU_RES_VEC 16'hFFFC
`define CPU_IRQ_VEC 16'hFFFE

// status register layout
// bits 3 and 4 read as zero, bit 5 reads as one
`define FLAG_C 0
`define FLAG_Z 1
`define FLAG_I 2
`define FLAG_V 6
`define FLAG_N 7

`endif
